//--- src/decode_pkg.sv
package decode_pkg;

   localparam int xlen   = 64;
   localparam int lg_prf = 6;

   localparam logic [1:0] priv_user    = 2'd0;
   localparam logic [1:0] priv_super   = 2'd1;
   localparam logic [1:0] priv_machine = 2'd3;

   localparam logic [6:0] opc_load   = 7'h03;
   localparam logic [6:0] opc_op_imm = 7'h13;
   localparam logic [6:0] opc_auipc  = 7'h17;
   localparam logic [6:0] opc_store  = 7'h23;
   localparam logic [6:0] opc_op     = 7'h33;
   localparam logic [6:0] opc_lui    = 7'h37;
   localparam logic [6:0] opc_branch = 7'h63;
   localparam logic [6:0] opc_jalr   = 7'h67;
   localparam logic [6:0] opc_jal    = 7'h6f;
   localparam logic [6:0] opc_system = 7'h73;

   localparam logic [4:0] link_reg_a = 5'd1; // ra
   localparam logic [4:0] link_reg_b = 5'd5; // t0, alternate link

   typedef enum logic [6:0] {
      op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
      op_sb, op_sh, op_sw, op_sd,
      op_addi, op_slli, op_slti, op_sltiu, op_xori, op_srli, op_srai, op_ori, op_andi,
      op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and,
      op_mul, op_mulh, op_mulhsu, op_mulhu, op_div, op_divu, op_rem, op_remu,
      op_lui, op_auipc,
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
      op_j, op_jal, op_jalr, op_jr, op_ret,
      op_ecall, op_ebreak, op_sret, op_mret,
      op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci,
      op_nop, op_ii, op_fetch_pf, op_irq
   } uop_op_t;

   typedef enum logic [5:0] {
      csr_sstatus, csr_sie, csr_stvec, csr_scounteren, csr_sscratch,
      csr_sepc, csr_scause, csr_stval, csr_sip, csr_satp,
      csr_mstatus, csr_misa, csr_medeleg, csr_mideleg, csr_mie, csr_mtvec,
      csr_mcounteren, csr_mscratch, csr_mepc, csr_mcause, csr_mtval, csr_mip,
      csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid,
      bad_csr = 6'h3f
   } csr_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } insn_r_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } insn_i_t;

   typedef struct packed {
      logic [11:0] csr;
      logic [4:0]  uimm; // rs1 for register forms
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } insn_csr_t;

   typedef union packed {
      insn_r_t   r;
      insn_i_t   i;
      insn_csr_t c;
   } insn_u;

   typedef struct packed {
      insn_u            insn;
      logic [xlen-1:0]  pc;
      logic [1:0]       priv;
      logic             page_fault;
      logic             irq;
   } fetch_t;

   typedef struct packed {
      uop_op_t           op;
      logic [lg_prf-1:0] src_a;
      logic              src_a_valid;
      logic [lg_prf-1:0] src_b;
      logic              src_b_valid;
      logic [lg_prf-1:0] dst;
      logic              dst_valid;
      logic [15:0]       imm16; // uimm and csr id
      logic [xlen-1:0]   rvimm;
      logic [xlen-1:0]   pc;
      logic              is_mem;
      logic              is_store;
      logic              is_int;
      logic              is_cheap_int;
      logic              is_br;
      logic              serializing;
      logic              must_restart;
   } uop_t;

   function automatic logic [lg_prf-1:0] reg_ext(logic [4:0] r);
      return {{(lg_prf-5){1'b0}}, r};
   endfunction

   // illegal op, nothing valid, pc carried along
   function automatic uop_t uop_init(fetch_t f);
      uop_t u;
      u = '0;
      u.op = op_ii;
      u.pc = f.pc;
      return u;
   endfunction

endpackage

//--- src/csr_map.sv
module csr_map (
   input  logic [11:0]       csr_addr,
   input  logic [1:0]        priv,
   output decode_pkg::csr_t  csr_id
);

   decode_pkg::csr_t id;
   logic [1:0]       min_priv;

   always_comb
   begin
      case (csr_addr)
         12'h100: id = decode_pkg::csr_sstatus;
         12'h104: id = decode_pkg::csr_sie;
         12'h105: id = decode_pkg::csr_stvec;
         12'h106: id = decode_pkg::csr_scounteren;
         12'h140: id = decode_pkg::csr_sscratch;
         12'h141: id = decode_pkg::csr_sepc;
         12'h142: id = decode_pkg::csr_scause;
         12'h143: id = decode_pkg::csr_stval;
         12'h144: id = decode_pkg::csr_sip;
         12'h180: id = decode_pkg::csr_satp;
         12'h300: id = decode_pkg::csr_mstatus;
         12'h301: id = decode_pkg::csr_misa;
         12'h302: id = decode_pkg::csr_medeleg;
         12'h303: id = decode_pkg::csr_mideleg;
         12'h304: id = decode_pkg::csr_mie;
         12'h305: id = decode_pkg::csr_mtvec;
         12'h306: id = decode_pkg::csr_mcounteren;
         12'h340: id = decode_pkg::csr_mscratch;
         12'h341: id = decode_pkg::csr_mepc;
         12'h342: id = decode_pkg::csr_mcause;
         12'h343: id = decode_pkg::csr_mtval;
         12'h344: id = decode_pkg::csr_mip;
         12'hf11: id = decode_pkg::csr_mvendorid;
         12'hf12: id = decode_pkg::csr_marchid;
         12'hf13: id = decode_pkg::csr_mimpid;
         12'hf14: id = decode_pkg::csr_mhartid;
         default: id = decode_pkg::bad_csr;
      endcase
   end

   // addr bits 9:8 give the lowest privilege allowed
   assign min_priv = (csr_addr[9:8] == 2'b01) ? decode_pkg::priv_super
                                              : decode_pkg::priv_machine;

   assign csr_id = (priv < min_priv) ? decode_pkg::bad_csr : id;

endmodule

//--- src/imm_gen.sv
module imm_gen (
   input  decode_pkg::insn_u               insn,
   input  logic [decode_pkg::xlen-1:0]     pc,
   output logic [decode_pkg::xlen-1:0]     imm_i,
   output logic [decode_pkg::xlen-1:0]     imm_s,
   output logic [decode_pkg::xlen-1:0]     imm_u,
   output logic [decode_pkg::xlen-1:0]     pc_target
);

   localparam int xl = decode_pkg::xlen;

   logic [xl-1:0] imm_b;
   logic [xl-1:0] imm_j;
   logic [xl-1:0] pc_off;

   assign imm_i = {{(xl-12){insn.i.imm12[11]}}, insn.i.imm12};
   assign imm_s = {{(xl-12){insn.r.funct7[6]}}, insn.r.funct7, insn.r.rd};
   assign imm_u = {{(xl-32){insn[31]}}, insn[31:12], 12'd0};

   // scrambled b and j fields
   assign imm_b = {{(xl-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
   assign imm_j = {{(xl-20){insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

   always_comb
   begin
      case (insn.r.opcode)
         decode_pkg::opc_auipc:
         begin
            pc_off = imm_u;
         end
         decode_pkg::opc_branch:
         begin
            pc_off = imm_b;
         end
         decode_pkg::opc_jal:
         begin
            pc_off = imm_j;
         end
         default:
         begin
            pc_off = '0;
         end
      endcase
   end

   assign pc_target = pc + pc_off;

endmodule

//--- src/int_decode.sv
module int_decode (
   input  decode_pkg::fetch_t              fetch,
   input  logic [decode_pkg::xlen-1:0]     imm_i,
   input  logic [decode_pkg::xlen-1:0]     imm_s,
   input  logic [decode_pkg::xlen-1:0]     imm_u,
   input  logic [decode_pkg::xlen-1:0]     pc_target,
   output decode_pkg::uop_t                uop
);

   decode_pkg::insn_r_t r;
   logic                rd_zero;
   logic                rs1_link;
   logic                alu;

   assign r        = fetch.insn.r;
   assign rd_zero  = (r.rd == 5'd0);
   assign rs1_link = (r.rs1 == decode_pkg::link_reg_a) || (r.rs1 == decode_pkg::link_reg_b);

   always_comb
   begin
      uop = decode_pkg::uop_init(fetch);
      alu = 1'b0;
      uop.dst   = decode_pkg::reg_ext(r.rd);
      uop.src_a = decode_pkg::reg_ext(r.rs1);
      uop.src_b = decode_pkg::reg_ext(r.rs2);
      case (r.opcode)
         decode_pkg::opc_load:
         begin
            uop.dst_valid = !rd_zero;
            uop.src_a_valid = 1'b1;
            uop.is_mem = 1'b1;
            uop.rvimm = imm_i;
            case (r.funct3)
               3'd0: uop.op = decode_pkg::op_lb;
               3'd1: uop.op = decode_pkg::op_lh;
               3'd2: uop.op = decode_pkg::op_lw;
               3'd3: uop.op = decode_pkg::op_ld;
               3'd4: uop.op = decode_pkg::op_lbu;
               3'd5: uop.op = decode_pkg::op_lhu;
               3'd6: uop.op = decode_pkg::op_lwu;
               default: uop.op = decode_pkg::op_ii;
            endcase
         end
         decode_pkg::opc_store:
         begin
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_mem = 1'b1;
            uop.is_store = 1'b1;
            uop.rvimm = imm_s;
            case (r.funct3)
               3'd0: uop.op = decode_pkg::op_sb;
               3'd1: uop.op = decode_pkg::op_sh;
               3'd2: uop.op = decode_pkg::op_sw;
               3'd3: uop.op = decode_pkg::op_sd;
               default: uop.op = decode_pkg::op_ii;
            endcase
         end
         decode_pkg::opc_op_imm:
         begin
            alu = 1'b1;
            uop.src_a_valid = !rd_zero;
            uop.is_cheap_int = 1'b1; // single source
            uop.rvimm = imm_i;
            case (r.funct3)
               3'd0: uop.op = decode_pkg::op_addi;
               3'd1: uop.op = (r.funct7[6:1] == 6'h00) ? decode_pkg::op_slli : decode_pkg::op_ii;
               3'd2: uop.op = decode_pkg::op_slti;
               3'd3: uop.op = decode_pkg::op_sltiu;
               3'd4: uop.op = decode_pkg::op_xori;
               3'd5:
               begin
                  if (r.funct7[6:1] == 6'h00)
                     uop.op = decode_pkg::op_srli;
                  else if (r.funct7[6:1] == 6'h10)
                     uop.op = decode_pkg::op_srai;
               end
               3'd6: uop.op = decode_pkg::op_ori;
               default: uop.op = decode_pkg::op_andi;
            endcase
         end
         decode_pkg::opc_op:
         begin
            alu = 1'b1;
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            case ({r.funct7, r.funct3})
               {7'h00, 3'd0}: uop.op = decode_pkg::op_add;
               {7'h20, 3'd0}: uop.op = decode_pkg::op_sub;
               {7'h00, 3'd1}: uop.op = decode_pkg::op_sll;
               {7'h00, 3'd2}: uop.op = decode_pkg::op_slt;
               {7'h00, 3'd3}: uop.op = decode_pkg::op_sltu;
               {7'h00, 3'd4}: uop.op = decode_pkg::op_xor;
               {7'h00, 3'd5}: uop.op = decode_pkg::op_srl;
               {7'h20, 3'd5}: uop.op = decode_pkg::op_sra;
               {7'h00, 3'd6}: uop.op = decode_pkg::op_or;
               {7'h00, 3'd7}: uop.op = decode_pkg::op_and;
               {7'h01, 3'd0}: uop.op = decode_pkg::op_mul;
               {7'h01, 3'd1}: uop.op = decode_pkg::op_mulh;
               {7'h01, 3'd2}: uop.op = decode_pkg::op_mulhsu;
               {7'h01, 3'd3}: uop.op = decode_pkg::op_mulhu;
               {7'h01, 3'd4}: uop.op = decode_pkg::op_div;
               {7'h01, 3'd5}: uop.op = decode_pkg::op_divu;
               {7'h01, 3'd6}: uop.op = decode_pkg::op_rem;
               {7'h01, 3'd7}: uop.op = decode_pkg::op_remu;
               default: uop.op = decode_pkg::op_ii;
            endcase
         end
         decode_pkg::opc_lui, decode_pkg::opc_auipc:
         begin
            alu = 1'b1;
            uop.is_cheap_int = 1'b1;
            uop.op = (r.opcode == decode_pkg::opc_lui) ? decode_pkg::op_lui : decode_pkg::op_auipc;
            uop.rvimm = (r.opcode == decode_pkg::opc_lui) ? imm_u : pc_target;
         end
         decode_pkg::opc_branch:
         begin
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_int = 1'b1;
            uop.is_br = 1'b1;
            uop.rvimm = pc_target;
            case (r.funct3)
               3'd0: uop.op = decode_pkg::op_beq;
               3'd1: uop.op = decode_pkg::op_bne;
               3'd4: uop.op = decode_pkg::op_blt;
               3'd5: uop.op = decode_pkg::op_bge;
               3'd6: uop.op = decode_pkg::op_bltu;
               3'd7: uop.op = decode_pkg::op_bgeu;
               default: uop.op = decode_pkg::op_ii;
            endcase
         end
         decode_pkg::opc_jalr:
         begin
            uop.src_a_valid = 1'b1;
            uop.dst_valid = !rd_zero;
            uop.is_int = 1'b1;
            uop.is_br = 1'b1;
            uop.is_cheap_int = 1'b1;
            uop.rvimm = imm_i;
            if (r.funct3 != 3'd0)
               uop.op = decode_pkg::op_ii;
            else if (!rd_zero)
               uop.op = decode_pkg::op_jalr;
            else
               uop.op = rs1_link ? decode_pkg::op_ret : decode_pkg::op_jr; // no link written
         end
         decode_pkg::opc_jal:
         begin
            uop.dst_valid = !rd_zero;
            uop.is_int = 1'b1;
            uop.is_br = 1'b1;
            uop.is_cheap_int = !rd_zero;
            uop.rvimm = pc_target;
            uop.op = rd_zero ? decode_pkg::op_j : decode_pkg::op_jal;
         end
         default:
         begin
            uop.op = decode_pkg::op_ii;
         end
      endcase
      if (alu)
      begin
         uop.is_int = 1'b1;
         uop.dst_valid = !rd_zero;
         if (rd_zero && uop.op != decode_pkg::op_ii)
            uop.op = decode_pkg::op_nop; // result to x0 is dropped
      end
   end

endmodule

//--- src/sys_decode.sv
module sys_decode (
   input  decode_pkg::fetch_t  fetch,
   output decode_pkg::uop_t    uop,
   output logic                sys_hit
);

   decode_pkg::insn_csr_t c;
   decode_pkg::csr_t      csr_id;
   logic                  no_regs;

   assign c       = fetch.insn.c;
   assign sys_hit = (c.opcode == decode_pkg::opc_system);
   assign no_regs = ({c.uimm, c.funct3, c.rd} == 13'd0);

   csr_map u_csr_map (
      .csr_addr (c.csr),
      .priv     (fetch.priv),
      .csr_id   (csr_id)
   );

   always_comb
   begin
      uop = decode_pkg::uop_init(fetch);
      uop.is_int = 1'b1;
      if (no_regs && (c.csr == 12'h000 || c.csr == 12'h001))
      begin
         uop.op = (c.csr[0]) ? decode_pkg::op_ebreak : decode_pkg::op_ecall;
         uop.serializing = 1'b1;
         uop.must_restart = 1'b1;
      end
      else if (no_regs && c.csr == 12'h102)
      begin
         if (fetch.priv != decode_pkg::priv_user)
         begin
            uop.op = decode_pkg::op_sret;
            uop.serializing = 1'b1;
            uop.must_restart = 1'b1;
            uop.imm16 = {10'd0, decode_pkg::csr_mstatus};
         end
      end
      else if (no_regs && c.csr == 12'h105)
      begin
         uop.op = decode_pkg::op_nop; // wfi
      end
      else if (no_regs && c.csr == 12'h302)
      begin
         if (fetch.priv == decode_pkg::priv_machine)
         begin
            uop.op = decode_pkg::op_mret;
            uop.serializing = 1'b1;
            uop.must_restart = 1'b1;
            uop.imm16 = {10'd0, decode_pkg::csr_mstatus};
         end
      end
      else if (c.funct3[1:0] != 2'b00 && csr_id != decode_pkg::bad_csr)
      begin
         uop.imm16 = {5'd0, c.uimm, csr_id};
         uop.dst = decode_pkg::reg_ext(c.rd);
         uop.dst_valid = (c.rd != 5'd0);
         uop.src_a = decode_pkg::reg_ext(c.uimm);
         uop.src_a_valid = !c.funct3[2]; // immediate forms read no register
         uop.serializing = 1'b1;
         uop.must_restart = 1'b1;
         case (c.funct3)
            3'd1: uop.op = decode_pkg::op_csrrw;
            3'd2: uop.op = decode_pkg::op_csrrs;
            3'd3: uop.op = decode_pkg::op_csrrc;
            3'd5: uop.op = decode_pkg::op_csrrwi;
            3'd6: uop.op = decode_pkg::op_csrrsi;
            default: uop.op = decode_pkg::op_csrrci;
         endcase
      end
   end

endmodule

//--- src/decode_stage.sv
module decode_stage (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                in_valid,
   output logic                in_ready,
   input  decode_pkg::fetch_t  fetch,
   output logic                out_valid,
   input  logic                out_ready,
   output decode_pkg::uop_t    uop
);

   logic [decode_pkg::xlen-1:0] imm_i;
   logic [decode_pkg::xlen-1:0] imm_s;
   logic [decode_pkg::xlen-1:0] imm_u;
   logic [decode_pkg::xlen-1:0] pc_target;
   decode_pkg::uop_t            int_uop;
   decode_pkg::uop_t            sys_uop;
   decode_pkg::uop_t            next_uop;
   logic                        sys_hit;

   imm_gen u_imm_gen (
      .insn      (fetch.insn),
      .pc        (fetch.pc),
      .imm_i     (imm_i),
      .imm_s     (imm_s),
      .imm_u     (imm_u),
      .pc_target (pc_target)
   );

   int_decode u_int_decode (
      .fetch     (fetch),
      .imm_i     (imm_i),
      .imm_s     (imm_s),
      .imm_u     (imm_u),
      .pc_target (pc_target),
      .uop       (int_uop)
   );

   sys_decode u_sys_decode (
      .fetch     (fetch),
      .uop       (sys_uop),
      .sys_hit   (sys_hit)
   );

   always_comb
   begin
      next_uop = sys_hit ? sys_uop : int_uop;
      if (fetch.page_fault || fetch.irq)
      begin
         next_uop = decode_pkg::uop_init(fetch); // drop all decode results
         next_uop.op = fetch.page_fault ? decode_pkg::op_fetch_pf : decode_pkg::op_irq;
      end
   end

   assign in_ready = !out_valid || out_ready;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         out_valid <= 1'b0;
      else if (in_ready)
         out_valid <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
         uop <= next_uop;
   end

endmodule

//--- verif/decode_properties.sv
module decode_properties (
   input logic                clk,
   input logic                arst_n,
   input logic                in_valid,
   input logic                in_ready,
   input decode_pkg::fetch_t  fetch,
   input logic                out_valid,
   input logic                out_ready,
   input decode_pkg::uop_t    uop
);

   int                          fail_count = 0;
   logic                        seen_accept;
   logic                        take;
   logic                        clean;
   logic                        alu_word;
   decode_pkg::insn_r_t         r;
   logic [decode_pkg::xlen-1:0] want_target;
   decode_pkg::uop_op_t         want_csr_op;

   function automatic logic [decode_pkg::xlen-1:0] branch_offset(logic [31:0] w);
      return {{(decode_pkg::xlen-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
   endfunction

   function automatic logic [decode_pkg::xlen-1:0] jump_offset(logic [31:0] w);
      return {{(decode_pkg::xlen-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
   endfunction

   function automatic logic [decode_pkg::lg_prf-1:0] widen(logic [4:0] v);
      logic [decode_pkg::lg_prf-1:0] x;
      x = '0;
      x[4:0] = v;
      return x;
   endfunction

   // machine csrs that exist in the table
   function automatic logic machine_listed(logic [11:0] a);
      return (a >= 12'h300 && a <= 12'h306) || (a >= 12'h340 && a <= 12'h344);
   endfunction

   function automatic decode_pkg::uop_op_t csr_op_of(logic [2:0] f3);
      decode_pkg::uop_op_t op;
      case (f3)
         3'd1: op = decode_pkg::op_csrrw;
         3'd2: op = decode_pkg::op_csrrs;
         3'd3: op = decode_pkg::op_csrrc;
         3'd5: op = decode_pkg::op_csrrwi;
         3'd6: op = decode_pkg::op_csrrsi;
         3'd7: op = decode_pkg::op_csrrci;
         default: op = decode_pkg::op_ii;
      endcase
      return op;
   endfunction

   assign take     = in_valid && in_ready;
   assign clean    = !fetch.page_fault && !fetch.irq;
   assign r        = fetch.insn.r;
   assign alu_word = (r.opcode == decode_pkg::opc_op_imm) || (r.opcode == decode_pkg::opc_op);
   assign want_target = fetch.pc + ((r.opcode == decode_pkg::opc_jal) ? jump_offset(fetch.insn)
                                                                      : branch_offset(fetch.insn));
   assign want_csr_op = csr_op_of(r.funct3);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         seen_accept <= 1'b0;
      else if (take)
         seen_accept <= 1'b1;
   end

   no_early_valid: assert property (@(posedge clk) disable iff (!arst_n)
      !seen_accept |-> !out_valid)
   else
   begin
      $error("out_valid high before any word was accepted");
      fail_count++;
   end

   hold_under_stall: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(uop))
   else
   begin
      $error("uop changed or was dropped while stalled");
      fail_count++;
   end

   ready_rule: assert property (@(posedge clk) disable iff (!arst_n)
      in_ready == (!out_valid || out_ready))
   else
   begin
      $error("in_ready does not follow out_valid and out_ready");
      fail_count++;
   end

   one_cycle_latency: assert property (@(posedge clk) disable iff (!arst_n)
      take |=> out_valid)
   else
   begin
      $error("accepted word did not show up one cycle later");
      fail_count++;
   end

   // only encodings that are always legal, so ii never hides the nop
   x0_gives_nop: assert property (@(posedge clk) disable iff (!arst_n)
      take && clean && r.rd == 5'd0 &&
      ((r.opcode == decode_pkg::opc_op_imm && r.funct3 != 3'd1 && r.funct3 != 3'd5) ||
       (r.opcode == decode_pkg::opc_op && r.funct7 == 7'h00))
      |=> uop.op == decode_pkg::op_nop && !uop.dst_valid)
   else
   begin
      $error("alu write to x0 did not become a nop");
      fail_count++;
   end

   dst_is_rd: assert property (@(posedge clk) disable iff (!arst_n)
      take && clean && alu_word && r.rd != 5'd0
      |=> uop.dst == widen($past(r.rd)) && uop.dst_valid)
   else
   begin
      $error("alu destination does not match rd");
      fail_count++;
   end

   pc_rel_target: assert property (@(posedge clk) disable iff (!arst_n)
      take && clean && (r.opcode == decode_pkg::opc_branch || r.opcode == decode_pkg::opc_jal)
      |=> uop.rvimm == $past(want_target))
   else
   begin
      $error("branch or jal target is not pc plus offset");
      fail_count++;
   end

   csr_user_denied: assert property (@(posedge clk) disable iff (!arst_n)
      take && clean && r.opcode == decode_pkg::opc_system && r.funct3[1:0] != 2'b00 &&
      fetch.insn.c.csr[11:8] == 4'h3 && fetch.priv == decode_pkg::priv_user
      |=> uop.op == decode_pkg::op_ii)
   else
   begin
      $error("machine csr access from user mode was not illegal");
      fail_count++;
   end

   csr_machine_ok: assert property (@(posedge clk) disable iff (!arst_n)
      take && clean && r.opcode == decode_pkg::opc_system && r.funct3[1:0] != 2'b00 &&
      machine_listed(fetch.insn.c.csr) && fetch.priv == decode_pkg::priv_machine
      |=> uop.op == $past(want_csr_op) && uop.serializing)
   else
   begin
      $error("machine csr access from machine mode decoded wrong");
      fail_count++;
   end

   page_fault_wins: assert property (@(posedge clk) disable iff (!arst_n)
      take && fetch.page_fault
      |=> uop.op == decode_pkg::op_fetch_pf && !uop.dst_valid && !uop.src_a_valid)
   else
   begin
      $error("page fault did not give fetch_pf");
      fail_count++;
   end

   irq_override: assert property (@(posedge clk) disable iff (!arst_n)
      take && fetch.irq && !fetch.page_fault
      |=> uop.op == decode_pkg::op_irq && !uop.dst_valid && !uop.src_b_valid)
   else
   begin
      $error("interrupt did not give irq");
      fail_count++;
   end

endmodule

bind decode_stage decode_properties props_inst (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .fetch     (fetch),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .uop       (uop)
);

//--- verif/tb_decode.sv
module tb_decode;

   localparam int n_directed = 10;
   localparam int n_items    = 400;
   localparam int period     = 4;

   logic               clk;
   logic               arst_n;
   logic               in_valid;
   logic               in_ready;
   decode_pkg::fetch_t fetch;
   logic               out_valid;
   logic               out_ready;
   decode_pkg::uop_t   uop;

   logic [31:0] seed;
   int          n_in;
   int          n_out;
   int          item_errors;
   int          sent;
   logic        took;

   decode_stage decode_stage_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .fetch     (fetch),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .uop       (uop)
   );

   initial
   begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift(logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      seed = xorshift(seed);
      return seed;
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] r;
      logic [31:0] w;
      logic [6:0]  opc;
      r = next_rand();
      w = next_rand();
      case (r[3:0])
         4'd0: opc = decode_pkg::opc_load;
         4'd1: opc = decode_pkg::opc_op_imm;
         4'd2: opc = decode_pkg::opc_auipc;
         4'd3: opc = decode_pkg::opc_store;
         4'd4, 4'd5: opc = decode_pkg::opc_op;
         4'd6: opc = decode_pkg::opc_lui;
         4'd7, 4'd8: opc = decode_pkg::opc_branch;
         4'd9: opc = decode_pkg::opc_jalr;
         4'd10: opc = decode_pkg::opc_jal;
         default: opc = decode_pkg::opc_system;
      endcase
      w[6:0] = opc;
      if (opc == decode_pkg::opc_op && r[5:4] != 2'd3)
         w[31:25] = (r[5:4] == 2'd0) ? 7'h00 : ((r[5:4] == 2'd1) ? 7'h20 : 7'h01);
      if (opc == decode_pkg::opc_system && r[6])
         w[31:20] = {4'h3, 1'b0, r[7], 3'b000, r[10:8]}; // 0x30x and 0x34x
      return w;
   endfunction

   function automatic decode_pkg::fetch_t make_item(int k);
      decode_pkg::fetch_t f;
      logic [31:0]        r;
      logic [31:0]        w;
      r = next_rand();
      f = '0;
      f.pc = {next_rand(), next_rand() & 32'hffff_fffc};
      f.priv = decode_pkg::priv_machine;
      case (k)
         0: w = {12'd5, 5'd0, 3'd0, 5'd0, decode_pkg::opc_op_imm}; // addi x0
         1: w = {7'h00, 5'd2, 5'd1, 3'd0, 5'd0, decode_pkg::opc_op};
         2: w = {12'd1, 5'd1, 3'd0, 5'd7, decode_pkg::opc_op_imm};
         3: w = {7'h7f, 5'd2, 5'd1, 3'd1, 5'h1d, decode_pkg::opc_branch}; // backward bne
         4: w = {20'h01000, 5'd1, decode_pkg::opc_jal};
         5, 6: w = {12'h300, 5'd6, 3'd1, 5'd5, decode_pkg::opc_system}; // csrrw mstatus
         7: w = {12'h341, 5'd3, 3'd6, 5'd9, decode_pkg::opc_system};
         8, 9: w = {12'd1, 5'd1, 3'd0, 5'd7, decode_pkg::opc_op_imm};
         default: w = random_word();
      endcase
      f.insn = w;
      if (k == 5)
         f.priv = decode_pkg::priv_user;
      if (k >= n_directed)
      begin
         case (r[5:4])
            2'd0: f.priv = decode_pkg::priv_user;
            2'd1: f.priv = decode_pkg::priv_super;
            default: f.priv = decode_pkg::priv_machine;
         endcase
      end
      f.page_fault = (k == 8) || (k >= n_directed && (r[3:0] == 4'd0 || r[3:0] == 4'd2));
      f.irq = (k == 9) || (k >= n_directed && (r[3:0] == 4'd1 || r[3:0] == 4'd2));
      return f;
   endfunction

   // handshake counts read by the stimulus 1 unit after the edge
   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         n_in = 0;
         n_out = 0;
         took = 1'b0;
      end
      else
      begin
         took = in_valid && in_ready;
         if (took)
            n_in++;
         if (out_valid && out_ready)
            n_out++;
      end
   end

   initial
   begin
      logic [31:0] r;
      arst_n = 1'b0;
      in_valid = 1'b0;
      out_ready = 1'b0;
      fetch = '0;
      seed = 32'h3131765f;
      item_errors = 0;
      sent = 0;
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;
      while (sent < n_items)
      begin
         @(posedge clk);
         #1;
         if (took)
            sent++;
         r = next_rand();
         out_ready = r[0] | r[1];
         if (!in_valid || took)
         begin
            in_valid = (sent < n_items) && (r[4:2] != 3'd0); // occasional bubble
            if (in_valid)
               fetch = make_item(sent);
         end
      end
      out_ready = 1'b1;
      while (n_out < n_in)
      begin
         @(posedge clk);
         #1;
      end
      repeat (2) @(posedge clk);
      #1;
      if (n_out != n_in)
      begin
         $display("mismatch delivered_items expected %0d actual %0d", n_in, n_out);
         item_errors++;
      end
      $display("errors: assertions %0d, items %0d, timeouts 0",
               decode_stage_inst.props_inst.fail_count, item_errors);
      if (decode_stage_inst.props_inst.fail_count == 0 && item_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   initial
   begin
      #((n_items * 8 + 10) * period);
      $display("timeout: the watchdog expired before all items were delivered");
      $display("errors: assertions %0d, items %0d, timeouts 1",
               decode_stage_inst.props_inst.fail_count, item_errors);
      $display("sim failed");
      $finish;
   end

endmodule

//--- sources.f
src/decode_pkg.sv
src/csr_map.sv
src/imm_gen.sv
src/int_decode.sv
src/sys_decode.sv
src/decode_stage.sv
verif/decode_properties.sv
verif/tb_decode.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_decode -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_decode +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
exit 1
